//--- Bender.yml
package:
  name: rv_core

sources:
  # packages first, the rtl depends on both
  - rtl/rv_isa_pkg.sv
  - rtl/core_cfg_pkg.sv
  - rtl/rv_decoder.sv
  - rtl/rv_alu.sv
  - rtl/register_file.sv
  - rtl/instr_mem.sv
  - rtl/data_mem.sv
  - rtl/rv_core_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/rv_core_asserts.sv
      - bench/tb_rv_core.sv

//--- bench/rv_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 run_i,
    input rv_isa_pkg::word_t    pc_i,
    input rv_isa_pkg::reg_idx_t rs1_idx_i,
    input rv_isa_pkg::word_t    rs1_data_i,
    input rv_isa_pkg::reg_idx_t rs2_idx_i,
    input rv_isa_pkg::word_t    rs2_data_i
);

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_i[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // pc frozen while idle
    a_pc_hold: assert property (@(posedge clk) disable iff (rst) !run_i |=> $stable(pc_i))
        else $error("pc moved while the run flag was clear");

    a_x0_rs1: assert property (@(posedge clk) disable iff (rst)
                               (rs1_idx_i == '0) |-> (rs1_data_i == '0))
        else $error("x0 read nonzero on rs1");
    a_x0_rs2: assert property (@(posedge clk) disable iff (rst)
                               (rs2_idx_i == '0) |-> (rs2_data_i == '0))
        else $error("x0 read nonzero on rs2");

endmodule

bind rv_core_top rv_core_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .run_i      (run_q),
    .pc_i       (pc_q),
    .rs1_idx_i  (instr[19:15]),
    .rs1_data_i (rs1_data),
    .rs2_idx_i  (instr[24:20]),
    .rs2_data_i (rs2_data)
);

`default_nettype wire

//--- bench/rv_iss_model.svh
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

// architectural state of the reference model
rv_isa_pkg::word_t iss_regs [32];
logic [7:0]        iss_mem  [core_cfg_pkg::DMEM_BYTES];
rv_isa_pkg::word_t iss_imem [core_cfg_pkg::IMEM_WORDS];
rv_isa_pkg::word_t iss_pc;

task automatic clear_model();
    for (int k = 0; k < 32; k++) iss_regs[k] = '0;
    for (int k = 0; k < core_cfg_pkg::DMEM_BYTES; k++) iss_mem[k] = '0;
    for (int k = 0; k < core_cfg_pkg::IMEM_WORDS; k++) iss_imem[k] = '0; // zero word is a no-op
    iss_pc = core_cfg_pkg::RESET_PC;
endtask

task automatic put_instr(input int idx, input rv_isa_pkg::word_t w);
    iss_imem[idx] = w;
endtask

function automatic rv_isa_pkg::word_t current_pc();
    return iss_pc;
endfunction

function automatic rv_isa_pkg::word_t a0_value();
    return iss_regs[10]; // x10 is a0
endfunction

function automatic rv_isa_pkg::word_t fetch_word();
    return iss_imem[iss_pc[9:2]]; // word index, wraps like the rom
endfunction

// branch rules straight from the isa manual
function automatic logic branch_cond(input logic [2:0] f3, input rv_isa_pkg::word_t a,
                                     input rv_isa_pkg::word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic rv_isa_pkg::word_t alu_calc(input logic [2:0] f3, input logic alt,
                                               input rv_isa_pkg::word_t a,
                                               input rv_isa_pkg::word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;  // sub only for OP
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? rv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// retire one instruction at iss_pc
task automatic exec_instr();
    rv_isa_pkg::word_t ins, a, b, res, nxt, imm_i, imm_s, imm_b, imm_j;
    logic [2:0]        f3;
    logic [4:0]        rd;
    logic              wr;
    logic [9:0]        ba; // byte address modulo memory size
    ins   = iss_imem[iss_pc[9:2]];
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = iss_regs[ins[19:15]];
    b     = iss_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt   = iss_pc + 32'd4;
    res   = '0;
    wr    = 1'b1;
    case (ins[6:0])
        rv_isa_pkg::OPC_LUI:   res = {ins[31:12], 12'h000};
        rv_isa_pkg::OPC_AUIPC: res = iss_pc + {ins[31:12], 12'h000};
        rv_isa_pkg::OPC_JAL: begin
            res = iss_pc + 32'd4;
            nxt = iss_pc + imm_j;
        end
        rv_isa_pkg::OPC_JALR: begin
            res = iss_pc + 32'd4;
            nxt = (a + imm_i) & 32'hffff_fffe; // lsb dropped
        end
        rv_isa_pkg::OPC_BRANCH: begin
            wr = 1'b0;
            if (branch_cond(f3, a, b)) nxt = iss_pc + imm_b;
        end
        rv_isa_pkg::OPC_LOAD: begin
            ba = 10'(a + imm_i);
            case (f3)
                rv_isa_pkg::F3_LW: res = {iss_mem[{ba[9:2], 2'd3}], iss_mem[{ba[9:2], 2'd2}],
                                          iss_mem[{ba[9:2], 2'd1}], iss_mem[{ba[9:2], 2'd0}]};
                rv_isa_pkg::F3_LB:  res = {{24{iss_mem[ba][7]}}, iss_mem[ba]};
                rv_isa_pkg::F3_LBU: res = {24'h0, iss_mem[ba]};
                default:            wr = 1'b0; // halfwords unsupported
            endcase
        end
        rv_isa_pkg::OPC_STORE: begin
            wr = 1'b0;
            ba = 10'(a + imm_s);
            if (f3 == rv_isa_pkg::F3_SW) begin
                for (int k = 0; k < 4; k++) iss_mem[{ba[9:2], 2'(k)}] = b[8*k +: 8];
            end else if (f3 == rv_isa_pkg::F3_SB) begin
                iss_mem[ba] = b[7:0];
            end
        end
        rv_isa_pkg::OPC_OPIMM: res = alu_calc(f3, ins[30] && f3 == rv_isa_pkg::F3_SRL, a, imm_i);
        rv_isa_pkg::OPC_OP:    res = alu_calc(f3, ins[30], a, b);
        default:               wr = 1'b0; // illegal, acts as nop
    endcase
    if (wr && rd != 5'd0) iss_regs[rd] = res; // x0 stays zero
    iss_pc = nxt;
endtask

`endif

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int PROG_LEN  = 200;
    localparam int MAX_STEPS = 2000;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     trigger_i;
    logic                     prog_we_i;
    core_cfg_pkg::imem_addr_t prog_addr_i;
    rv_isa_pkg::word_t        prog_data_i;
    rv_isa_pkg::word_t        a0_o;
    rv_isa_pkg::word_t        pc_o;

    rv_isa_pkg::word_t prog [PROG_LEN];
    logic              landed [PROG_LEN]; // slots that some jump targets
    int                errors;
    int                checks;

    rv_core_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .trigger_i   (trigger_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .a0_o        (a0_o),
        .pc_o        (pc_o)
    );

    always #5 clk = ~clk; // 10 ns

    // instruction encoders, field order from the isa
    function automatic rv_isa_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic rv_isa_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv_isa_pkg::OPC_STORE}; // base x0
    endfunction

    function automatic rv_isa_pkg::word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_isa_pkg::word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    function automatic logic [4:0] pick_rd();
        return ($urandom_range(0, 2) == 0) ? 5'd10 : 5'($urandom_range(0, 30)); // x31 kept
    endfunction

    // forward target a few slots ahead, never past the stop word
    function automatic int pick_target(input int lo);
        int t;
        t = lo + $urandom_range(0, 5);
        if (t > PROG_LEN - 1) t = PROG_LEN - 1;
        landed[t] = 1'b1;
        return t;
    endfunction

    function automatic logic [11:0] pick_offset();
        return ($urandom_range(0, 3) == 0) ? 12'($urandom_range(0, 1023)) :
                                             12'($urandom_range(0, 63)); // dense region
    endfunction

    task automatic build_program();
        int          i, kind, t;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic        alt;
        logic [2:0]  br_f3 [6];
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (i = 0; i < PROG_LEN; i++) landed[i] = 1'b0;
        i = 0;
        while (i < PROG_LEN - 1) begin
            kind = $urandom_range(0, 9);
            rd   = pick_rd();
            rs1  = 5'($urandom_range(0, 31));
            rs2  = 5'($urandom_range(0, 31));
            f3   = 3'($urandom_range(0, 7));
            alt  = 1'($urandom_range(0, 1));
            // jalr group needs three slots nobody jumps into
            if (kind == 7 && (i + 3 > PROG_LEN - 1 || landed[i+1] || landed[i+2])) kind = 1;
            case (kind)
                0: prog[i] = {20'($urandom), rd,
                              alt ? rv_isa_pkg::OPC_LUI : rv_isa_pkg::OPC_AUIPC};
                1, 2: begin
                    if (f3 == 3'b001 || f3 == 3'b101)  // shift immediates
                        prog[i] = i_type({1'b0, alt && f3 == 3'b101, 5'd0, 5'($urandom)},
                                         rs1, f3, rd, rv_isa_pkg::OPC_OPIMM);
                    else
                        prog[i] = i_type(12'($urandom), rs1, f3, rd, rv_isa_pkg::OPC_OPIMM);
                end
                3, 4: prog[i] = r_type({1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'd0},
                                       rs2, rs1, f3, rd);
                5: begin
                    if ($urandom_range(0, 3) == 0) rs2 = rs1; // equal operands now and then
                    t       = pick_target(i + 1);
                    prog[i] = b_type(13'((t - i) * 4), rs2, rs1, br_f3[$urandom_range(0, 5)]);
                end
                6: begin
                    t       = pick_target(i + 1);
                    prog[i] = j_type(21'((t - i) * 4), rd);
                end
                7: begin
                    t         = pick_target(i + 3);
                    prog[i]   = {20'h00000, 5'd31, rv_isa_pkg::OPC_LUI};
                    prog[i+1] = i_type(12'(t * 4), 5'd31, 3'b000, 5'd31, rv_isa_pkg::OPC_OPIMM);
                    prog[i+2] = i_type({11'd0, alt}, 5'd31, 3'b000, rd, rv_isa_pkg::OPC_JALR);
                    i         = i + 2;
                end
                8: prog[i] = s_type(pick_offset(), rs2,
                                    alt ? rv_isa_pkg::F3_SW : rv_isa_pkg::F3_SB);
                default: begin
                    t       = $urandom_range(0, 2);
                    f3      = (t == 0) ? rv_isa_pkg::F3_LW :
                              (t == 1) ? rv_isa_pkg::F3_LB : rv_isa_pkg::F3_LBU;
                    prog[i] = i_type(pick_offset(), 5'd0, f3, rd, rv_isa_pkg::OPC_LOAD);
                end
            endcase
            i++;
        end
        prog[PROG_LEN-1] = j_type(21'd0, 5'd0); // self loop marks the end
        for (i = 0; i < PROG_LEN; i++) put_instr(i, prog[i]);
    endtask

    task automatic check_outputs();
        checks++;
        if (pc_o !== current_pc()) begin
            errors++;
            $display("** Error at %0t: pc_o = %h, expected %h", $time, pc_o, current_pc());
        end
        if (a0_o !== a0_value()) begin
            errors++;
            $display("** Error at %0t: a0_o = %h, expected %h", $time, a0_o, a0_value());
        end
    endtask

    initial begin
        int          steps;
        logic        stopped;
        errors      = 0;
        checks      = 0;
        rst         = 1'b1;
        trigger_i   = 1'b0;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        void'($urandom(32'h4e78b70d));
        clear_model();
        build_program();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        // load while idle, pc and a0 must not move
        for (int k = 0; k < PROG_LEN; k++) begin
            prog_we_i   = 1'b1;
            prog_addr_i = core_cfg_pkg::imem_addr_t'(k);
            prog_data_i = prog[k];
            @(posedge clk);
            #1 check_outputs();
        end
        prog_we_i = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1 check_outputs();
        end
        trigger_i = 1'b1;
        @(posedge clk); // run flag set here
        #1 trigger_i = 1'b0;
        check_outputs();
        steps   = 0;
        stopped = 1'b0;
        while (!stopped && steps < MAX_STEPS) begin
            stopped = (fetch_word() == prog[PROG_LEN-1]); // last pass runs the self loop
            exec_instr();
            @(posedge clk);
            #1 check_outputs();
            steps++;
        end
        if (!stopped) begin
            errors++;
            $display("timeout: the stop marker was not reached within %0d cycles", MAX_STEPS);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    `include "rv_iss_model.svh"

endmodule

`default_nettype wire

//--- rtl/core_cfg_pkg.sv
`default_nettype none

// build options of this core and its internal control types
package core_cfg_pkg;

    localparam int IMEM_WORDS  = 256;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_BYTES  = 1024;
    localparam int DMEM_ADDR_W = $clog2(DMEM_BYTES);

    localparam rv_isa_pkg::word_t RESET_PC = '0;

    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t; // instruction word index
    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t; // data byte index

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    // control word from the decoder, 15 bits
    typedef struct packed {
        logic    reg_wr_en;
        logic    mem_wr_en;
        logic    mem_byte;    // byte-wide access
        logic    mem_signed;  // sign-extend byte loads
        logic    alu_src_imm; // operand b is the immediate
        logic    alu_a_pc;    // operand a is pc or zero (auipc, lui)
        alu_op_e alu_op;
        wb_sel_e wb_sel;
        logic    is_branch;
        logic    is_jal;
        logic    is_jalr;
    } ctrl_t;

endpackage

`default_nettype wire

//--- rtl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic              clk,
    input  rv_isa_pkg::word_t addr_i,
    input  rv_isa_pkg::word_t wr_data_i,
    input  logic              wr_en_i,
    input  logic              byte_i,   // byte access, else word
    input  logic              signed_i, // sign-extend byte reads
    output rv_isa_pkg::word_t rd_data_o
);

    logic [7:0]               mem [core_cfg_pkg::DMEM_BYTES];
    core_cfg_pkg::dmem_addr_t byte_addr; // address modulo DMEM_BYTES
    core_cfg_pkg::dmem_addr_t word_base; // low two bits cleared
    rv_isa_pkg::word_t        word_rd;
    logic [7:0]               byte_rd;

    assign byte_addr = addr_i[core_cfg_pkg::DMEM_ADDR_W-1:0];
    assign word_base = {byte_addr[core_cfg_pkg::DMEM_ADDR_W-1:2], 2'b00};

    initial begin
        for (int i = 0; i < core_cfg_pkg::DMEM_BYTES; i++) begin
            mem[i] = '0;
        end
    end

    // little endian, byte 0 at the lowest address
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            if (byte_i) begin
                mem[byte_addr] <= wr_data_i[7:0]; // one byte only
            end else begin
                for (int i = 0; i < 4; i++) begin
                    mem[word_base | core_cfg_pkg::dmem_addr_t'(i)] <= wr_data_i[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            word_rd[8*i +: 8] = mem[word_base | core_cfg_pkg::dmem_addr_t'(i)];
        end
    end

    assign byte_rd   = mem[byte_addr];
    assign rd_data_o = !byte_i ? word_rd :
                       {{24{signed_i & byte_rd[7]}}, byte_rd}; // lb or lbu

endmodule

`default_nettype wire

//--- rtl/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
    input  logic                     clk,
    input  rv_isa_pkg::word_t        addr_i,    // byte address from pc
    input  logic                     wr_en_i,   // program load strobe
    input  core_cfg_pkg::imem_addr_t wr_addr_i,
    input  rv_isa_pkg::word_t        wr_data_i,
    output rv_isa_pkg::word_t        instr_o
);

    rv_isa_pkg::word_t        mem [core_cfg_pkg::IMEM_WORDS];
    core_cfg_pkg::imem_addr_t rd_idx;

    // empty rom reads all zeros, an illegal opcode, so a no-op
    initial begin
        for (int i = 0; i < core_cfg_pkg::IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_idx  = addr_i[core_cfg_pkg::IMEM_ADDR_W+1:2]; // word index, wraps
    assign instr_o = mem[rd_idx];

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_isa_pkg::reg_idx_t rs1_i,
    input  rv_isa_pkg::reg_idx_t rs2_i,
    input  rv_isa_pkg::reg_idx_t rd_i,
    input  rv_isa_pkg::word_t    wr_data_i,
    input  logic                 wr_en_i,
    output rv_isa_pkg::word_t    rs1_data_o,
    output rv_isa_pkg::word_t    rs2_data_o,
    output rv_isa_pkg::word_t    a0_o
);

    rv_isa_pkg::word_t regs [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && rd_i != '0) begin
            regs[rd_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];
    assign a0_o       = regs[rv_isa_pkg::REG_A0]; // debug tap

endmodule

`default_nettype wire

//--- rtl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_isa_pkg::word_t     a_i,
    input  rv_isa_pkg::word_t     b_i,
    input  core_cfg_pkg::alu_op_e op_i,
    input  rv_isa_pkg::funct3_t   br_funct3_i,
    output rv_isa_pkg::word_t     result_o,
    output logic                  branch_taken_o
);

    logic [4:0] shamt;
    logic       lt_s;  // signed a < b
    logic       lt_u;  // unsigned a < b
    logic       eq;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign eq    = (a_i == b_i);

    always_comb begin
        case (op_i)
            core_cfg_pkg::ALU_SUB:    result_o = a_i - b_i;
            core_cfg_pkg::ALU_SLL:    result_o = a_i << shamt;
            core_cfg_pkg::ALU_SLT:    result_o = {31'b0, lt_s};
            core_cfg_pkg::ALU_SLTU:   result_o = {31'b0, lt_u};
            core_cfg_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            core_cfg_pkg::ALU_SRL:    result_o = a_i >> shamt;
            core_cfg_pkg::ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            core_cfg_pkg::ALU_OR:     result_o = a_i | b_i;
            core_cfg_pkg::ALU_AND:    result_o = a_i & b_i;
            core_cfg_pkg::ALU_PASS_B: result_o = b_i;
            default:                  result_o = a_i + b_i; // add, addresses too
        endcase
    end

    // branch condition on raw operands, whatever op_i is
    always_comb begin
        case (br_funct3_i)
            rv_isa_pkg::F3_BEQ:  branch_taken_o = eq;
            rv_isa_pkg::F3_BNE:  branch_taken_o = !eq;
            rv_isa_pkg::F3_BLT:  branch_taken_o = lt_s;
            rv_isa_pkg::F3_BGE:  branch_taken_o = !lt_s;
            rv_isa_pkg::F3_BLTU: branch_taken_o = lt_u;
            rv_isa_pkg::F3_BGEU: branch_taken_o = !lt_u;
            default:             branch_taken_o = 1'b0; // reserved encodings
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     trigger_i,
    input  logic                     prog_we_i,   // load port, idle only
    input  core_cfg_pkg::imem_addr_t prog_addr_i,
    input  rv_isa_pkg::word_t        prog_data_i,
    output rv_isa_pkg::word_t        a0_o,
    output rv_isa_pkg::word_t        pc_o
);

    logic                 run_q;     // set by trigger, held until reset
    rv_isa_pkg::word_t    pc_q;
    rv_isa_pkg::word_t    pc_next;
    rv_isa_pkg::word_t    pc_plus4;
    rv_isa_pkg::word_t    instr;
    rv_isa_pkg::word_t    imm;
    rv_isa_pkg::word_t    rs1_data, rs2_data;
    rv_isa_pkg::word_t    alu_a, alu_b, alu_result;
    rv_isa_pkg::word_t    mem_rd_data;
    rv_isa_pkg::word_t    wb_data;
    core_cfg_pkg::ctrl_t  ctrl;
    logic                 branch_taken;

    // trigger latch, follows trigger_i during reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q <= trigger_i;
        end else if (trigger_i) begin
            run_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= core_cfg_pkg::RESET_PC;
        end else if (run_q) begin
            pc_q <= pc_next; // one instruction per enabled edge
        end
    end

    instr_mem u_imem (
        .clk       (clk),
        .addr_i    (pc_q),
        .wr_en_i   (prog_we_i && !run_q),
        .wr_addr_i (prog_addr_i),
        .wr_data_i (prog_data_i),
        .instr_o   (instr)
    );

    rv_decoder u_dec (
        .instr_i (instr),
        .ctrl_o  (ctrl),
        .imm_o   (imm)
    );

    register_file u_rf (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (instr[19:15]),
        .rs2_i      (instr[24:20]),
        .rd_i       (instr[11:7]),
        .wr_data_i  (wb_data),
        .wr_en_i    (ctrl.reg_wr_en && run_q),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .a0_o       (a0_o)
    );

    // operand a: pc for auipc, zero for lui, else rs1
    always_comb begin
        if (!ctrl.alu_a_pc) begin
            alu_a = rs1_data;
        end else if (instr[6:0] == rv_isa_pkg::OPC_AUIPC) begin
            alu_a = pc_q;
        end else begin
            alu_a = '0;
        end
    end

    assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

    rv_alu u_alu (
        .a_i            (alu_a),
        .b_i            (alu_b),
        .op_i           (ctrl.alu_op),
        .br_funct3_i    (instr[14:12]),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    data_mem u_dmem (
        .clk       (clk),
        .addr_i    (alu_result),
        .wr_data_i (rs2_data),
        .wr_en_i   (ctrl.mem_wr_en && run_q),
        .byte_i    (ctrl.mem_byte),
        .signed_i  (ctrl.mem_signed),
        .rd_data_o (mem_rd_data)
    );

    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        if (ctrl.is_jalr) begin
            pc_next = (rs1_data + imm) & ~32'd1; // bit 0 cleared
        end else if (ctrl.is_jal || (ctrl.is_branch && branch_taken)) begin
            pc_next = pc_q + imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            core_cfg_pkg::WB_MEM: wb_data = mem_rd_data;
            core_cfg_pkg::WB_PC4: wb_data = pc_plus4; // link address
            default:              wb_data = alu_result;
        endcase
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- rtl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  rv_isa_pkg::word_t     instr_i,
    output core_cfg_pkg::ctrl_t   ctrl_o,
    output rv_isa_pkg::word_t     imm_o
);

    rv_isa_pkg::opcode_t    opcode;
    rv_isa_pkg::funct3_t    funct3;
    logic                   f7_b5;    // sub / sra select
    core_cfg_pkg::alu_op_e  arith_op; // op for OP and OP-IMM
    core_cfg_pkg::imm_sel_e imm_sel;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign f7_b5  = instr_i[30];

    // arithmetic group op, only OP uses funct7 for sub
    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_ADD:  arith_op = (opcode == rv_isa_pkg::OPC_OP && f7_b5) ?
                                            core_cfg_pkg::ALU_SUB : core_cfg_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  arith_op = core_cfg_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  arith_op = core_cfg_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: arith_op = core_cfg_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  arith_op = core_cfg_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL:  arith_op = f7_b5 ? core_cfg_pkg::ALU_SRA : core_cfg_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   arith_op = core_cfg_pkg::ALU_OR;
            default:             arith_op = core_cfg_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o  = '0; // no writes, plain pc+4
        imm_sel = core_cfg_pkg::IMM_I;
        case (opcode)
            rv_isa_pkg::OPC_LUI: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.alu_a_pc    = 1'b1; // top feeds zero for lui
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = core_cfg_pkg::ALU_PASS_B;
                imm_sel            = core_cfg_pkg::IMM_U;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.alu_a_pc    = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = core_cfg_pkg::ALU_ADD;
                imm_sel            = core_cfg_pkg::IMM_U;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.wb_sel    = core_cfg_pkg::WB_PC4; // link
                ctrl_o.is_jal    = 1'b1;
                imm_sel          = core_cfg_pkg::IMM_J;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.wb_sel    = core_cfg_pkg::WB_PC4;
                ctrl_o.is_jalr   = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                ctrl_o.is_branch = 1'b1; // condition from the alu compare
                ctrl_o.alu_op    = core_cfg_pkg::ALU_SUB;
                imm_sel          = core_cfg_pkg::IMM_B;
            end
            rv_isa_pkg::OPC_LOAD: begin
                // lb, lw, lbu only, the rest fall through as no-ops
                ctrl_o.reg_wr_en   = (funct3 == rv_isa_pkg::F3_LB) ||
                                     (funct3 == rv_isa_pkg::F3_LW) ||
                                     (funct3 == rv_isa_pkg::F3_LBU);
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.wb_sel      = core_cfg_pkg::WB_MEM;
                ctrl_o.mem_byte    = (funct3 != rv_isa_pkg::F3_LW);
                ctrl_o.mem_signed  = (funct3 == rv_isa_pkg::F3_LB);
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl_o.mem_wr_en   = (funct3 == rv_isa_pkg::F3_SB) ||
                                     (funct3 == rv_isa_pkg::F3_SW);
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_byte    = (funct3 == rv_isa_pkg::F3_SB);
                imm_sel            = core_cfg_pkg::IMM_S;
            end
            rv_isa_pkg::OPC_OPIMM: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = arith_op;
            end
            rv_isa_pkg::OPC_OP: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.alu_op    = arith_op;
            end
            default: ; // illegal opcode, nothing written
        endcase
    end

    // immediate extender, sign from bit 31
    always_comb begin
        case (imm_sel)
            core_cfg_pkg::IMM_S: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            core_cfg_pkg::IMM_B: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                          instr_i[30:25], instr_i[11:8], 1'b0};
            core_cfg_pkg::IMM_U: imm_o = {instr_i[31:12], 12'b0};
            core_cfg_pkg::IMM_J: imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                          instr_i[20], instr_i[30:21], 1'b0};
            default:             imm_o = {{20{instr_i[31]}}, instr_i[31:20]}; // I-type
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

// RV32I instruction set: field widths, word types, opcodes and function codes
package rv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;

    typedef logic [XLEN-1:0]      word_t;    // data, address or instruction
    typedef logic [REG_IDX_W-1:0] reg_idx_t; // x0..x31
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;

    // major opcodes, instr[6:0]
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // loads and stores, halfwords not supported
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SW  = 3'b010;

    // alu group, shared by OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000; // also SUB
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101; // also SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam reg_idx_t REG_A0 = 5'd10; // shown at the top level

endpackage

`default_nettype wire

//--- sim.f
+incdir+bench
rtl/rv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/register_file.sv
rtl/instr_mem.sv
rtl/data_mem.sv
rtl/rv_core_top.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv
